// ==== source/stepUnitPkg.sv ====
// Step unit definitions for microword layout, SCAD codes, entry points and the data word
package stepUnitPkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   localparam int WORD_W  = 36;
   localparam int SCAD_W  = 10;
   localparam int UADDR_W = 6;
   localparam int UWORD_W = 34;

   //////////////////////////////
   // Microword layout
   //////////////////////////////

   // Jump address sits in the top bits
   localparam int J_POS      = 28;
   localparam int J_W        = 6;
   localparam int DISP_POS   = 26;
   localparam int DISP_W     = 2;
   localparam int FUN_POS    = 23;
   localparam int FUN_W      = 3;
   localparam int ASEL_POS   = 20;
   localparam int ASEL_W     = 3;
   localparam int BSEL_POS   = 18;
   localparam int BSEL_W     = 2;
   localparam int SNUM_POS   = 8;
   localparam int SNUM_W     = 10;
   // Single bit controls
   localparam int LOADSC_POS = 7;
   localparam int LOADFE_POS = 6;
   localparam int DPSEL_POS  = 5;
   localparam int SHIFT_POS  = 3;
   localparam int SHIFT_W    = 2;
   localparam int DONE_POS   = 2;
   localparam int RESSEL_POS = 0;
   localparam int RESSEL_W   = 2;

   // SCAD ALU functions in truth table order
   localparam logic [2:0] FUN_A_PLUS_A    = 3'd0;
   localparam logic [2:0] FUN_A_OR_B      = 3'd1;
   localparam logic [2:0] FUN_A_MINUS_B_1 = 3'd2;
   localparam logic [2:0] FUN_A_MINUS_B   = 3'd3;
   localparam logic [2:0] FUN_A_PLUS_B    = 3'd4;
   localparam logic [2:0] FUN_A_AND_B     = 3'd5;
   localparam logic [2:0] FUN_A_MINUS_1   = 3'd6;
   localparam logic [2:0] FUN_A           = 3'd7;

   // SCADA selects
   localparam logic [2:0] ASEL_SC    = 3'd0;
   localparam logic [2:0] ASEL_SNUM  = 3'd1;
   localparam logic [2:0] ASEL_PTR44 = 3'd2;
   localparam logic [2:0] ASEL_BYTE1 = 3'd3;
   localparam logic [2:0] ASEL_BYTE2 = 3'd4;
   localparam logic [2:0] ASEL_BYTE3 = 3'd5;
   localparam logic [2:0] ASEL_BYTE4 = 3'd6;
   localparam logic [2:0] ASEL_BYTE5 = 3'd7;

   // SCADB selects
   localparam logic [1:0] BSEL_FE    = 2'd0;
   localparam logic [1:0] BSEL_EXP   = 2'd1;
   localparam logic [1:0] BSEL_SHIFT = 2'd2;
   localparam logic [1:0] BSEL_SIZE  = 2'd3;

   // Dispatch conditions ORed into the low address bit
   localparam logic [1:0] DISP_NONE     = 2'd0;
   localparam logic [1:0] DISP_SCADSIGN = 2'd1;
   localparam logic [1:0] DISP_FRACMSB  = 2'd2;
   localparam logic [1:0] DISP_SCSIGN   = 2'd3;

   // AR shifter, bus source and result source
   localparam logic [1:0] SH_HOLD        = 2'd0;
   localparam logic [1:0] SH_LEFT        = 2'd1;
   localparam logic [1:0] SH_RIGHT       = 2'd2;
   localparam logic       DP_AR          = 1'b0;
   localparam logic       DP_BR          = 1'b1;
   localparam logic [1:0] RES_AR         = 2'd0;
   localparam logic [1:0] RES_AR_WITH_FE = 2'd1;

   // Command codes and their microcode entry points
   localparam logic [1:0]         OP_NORM    = 2'd0;
   localparam logic [1:0]         OP_LSH     = 2'd1;
   localparam logic [1:0]         OP_FSC     = 2'd2;
   localparam logic [UADDR_W-1:0] IDLE_ADDR  = 6'o00;
   localparam logic [UADDR_W-1:0] ENTRY_NORM = 6'o10;
   localparam logic [UADDR_W-1:0] ENTRY_LSH  = 6'o20;
   localparam logic [UADDR_W-1:0] ENTRY_FSC  = 6'o30;

   // Data word seen as a float or as a shift count carrier
   typedef union packed {
      struct packed {
         logic        sign;
         logic [0:7]  exponent;
         logic [0:26] fraction;
      } floatView;
      struct packed {
         logic [0:17] upper;
         logic        countSign;
         logic [0:8]  gap;
         logic [0:7]  count;
      } shiftView;
   } dpWord_u;

endpackage

// ==== source/ucodeBus.sv ====
// Bundle carrying the microword, the SCAD results and the data bus between blocks
`timescale 1ns/1ps

interface ucodeBus;
   import stepUnitPkg::*;

   // Current microword out of the control store
   logic [UWORD_W-1:0] uword;
   // Operand load strobe on command accept
   logic               start;
   // Word that the SCAD muxes look at
   dpWord_u            dpBus;
   // ALU output and its sign
   logic [0:SCAD_W-1]  scadOut;
   logic               scadSign;
   logic               scSign;
   // AR bit 9 for normalize
   logic               fracMsb;
   logic [0:SCAD_W-1]  fe;

   // Sequencer watches the branch conditions
   modport sequencer (input uword, scadSign, fracMsb, scSign, output start);
   modport scad (input uword, dpBus, output scadOut, scadSign, scSign, fe);
   modport dataPath (input uword, start, fe, output dpBus, fracMsb);

endinterface

// ==== source/controlStore.sv ====
// Control store ROM with the NORM, LSH and FSC microprograms
`timescale 1ns/1ps

module controlStore (
   input  logic [stepUnitPkg::UADDR_W-1:0] addr,
   output logic [stepUnitPkg::UWORD_W-1:0] uword
);
   import stepUnitPkg::*;

   // Pack one microword from its fields
   function automatic logic [UWORD_W-1:0] microWord(
      input logic [J_W-1:0]      j,
      input logic [DISP_W-1:0]   disp,
      input logic [FUN_W-1:0]    fun,
      input logic [ASEL_W-1:0]   asel,
      input logic [BSEL_W-1:0]   bsel,
      input logic [SNUM_W-1:0]   snum,
      input logic                loadSc,
      input logic                loadFe,
      input logic                dpSel,
      input logic [SHIFT_W-1:0]  shift,
      input logic                done,
      input logic [RESSEL_W-1:0] resSel
   );
      logic [UWORD_W-1:0] w;
      w[J_POS +: J_W]           = j;
      w[DISP_POS +: DISP_W]     = disp;
      w[FUN_POS +: FUN_W]       = fun;
      w[ASEL_POS +: ASEL_W]     = asel;
      w[BSEL_POS +: BSEL_W]     = bsel;
      w[SNUM_POS +: SNUM_W]     = snum;
      w[LOADSC_POS]             = loadSc;
      w[LOADFE_POS]             = loadFe;
      w[DPSEL_POS]              = dpSel;
      w[SHIFT_POS +: SHIFT_W]   = shift;
      w[DONE_POS]               = done;
      w[RESSEL_POS +: RESSEL_W] = resSel;
      return w;
   endfunction

   always_comb
   begin
      case (addr)
         //////////////////////////////
         // NORM
         //////////////////////////////
         // FE from the exponent
         6'o10:
            uword = microWord(6'o11, DISP_NONE, FUN_A_PLUS_B, ASEL_SNUM, BSEL_EXP, 10'o0,
                              1'b0, 1'b1, DP_AR, SH_HOLD, 1'b0, RES_AR);
         // At most 27 shifts
         6'o11:
            uword = microWord(6'o16, DISP_NONE, FUN_A, ASEL_SNUM, BSEL_FE, 10'd26,
                              1'b1, 1'b0, DP_AR, SH_HOLD, 1'b0, RES_AR);
         // Exit once the fraction MSB is set
         6'o16:
            uword = microWord(6'o12, DISP_FRACMSB, FUN_A, ASEL_SC, BSEL_FE, 10'o0,
                              1'b0, 1'b0, DP_AR, SH_HOLD, 1'b0, RES_AR);
         // Shift left and take one off the exponent
         6'o12:
            uword = microWord(6'o14, DISP_NONE, FUN_A_PLUS_B, ASEL_SNUM, BSEL_FE, 10'o1777,
                              1'b0, 1'b1, DP_AR, SH_LEFT, 1'b0, RES_AR);
         // Count down, give up when SC goes negative
         6'o14:
            uword = microWord(6'o16, DISP_SCADSIGN, FUN_A_MINUS_1, ASEL_SC, BSEL_FE, 10'o0,
                              1'b1, 1'b0, DP_AR, SH_HOLD, 1'b0, RES_AR);
         6'o13, 6'o17:
            uword = microWord(IDLE_ADDR, DISP_NONE, FUN_A, ASEL_SC, BSEL_FE, 10'o0,
                              1'b0, 1'b0, DP_AR, SH_HOLD, 1'b1, RES_AR_WITH_FE);
         //////////////////////////////
         // LSH
         //////////////////////////////
         // Signed count from BR
         6'o20:
            uword = microWord(6'o21, DISP_NONE, FUN_A_PLUS_B, ASEL_SNUM, BSEL_SHIFT, 10'o0,
                              1'b1, 1'b0, DP_BR, SH_HOLD, 1'b0, RES_AR);
         // Negative count takes the right path
         6'o21:
            uword = microWord(6'o22, DISP_SCSIGN, FUN_A, ASEL_SC, BSEL_FE, 10'o0,
                              1'b0, 1'b0, DP_AR, SH_HOLD, 1'b0, RES_AR);
         // Zero count skips the loop
         6'o22:
            uword = microWord(6'o24, DISP_SCADSIGN, FUN_A_MINUS_1, ASEL_SC, BSEL_FE, 10'o0,
                              1'b1, 1'b0, DP_AR, SH_HOLD, 1'b0, RES_AR);
         6'o24:
            uword = microWord(6'o24, DISP_SCADSIGN, FUN_A_MINUS_1, ASEL_SC, BSEL_FE, 10'o0,
                              1'b1, 1'b0, DP_AR, SH_LEFT, 1'b0, RES_AR);
         // Magnitude of the negative count
         6'o23:
            uword = microWord(6'o40, DISP_NONE, FUN_A_MINUS_B, ASEL_SNUM, BSEL_SHIFT, 10'o0,
                              1'b1, 1'b0, DP_BR, SH_HOLD, 1'b0, RES_AR);
         6'o40:
            uword = microWord(6'o42, DISP_SCADSIGN, FUN_A_MINUS_1, ASEL_SC, BSEL_FE, 10'o0,
                              1'b1, 1'b0, DP_AR, SH_HOLD, 1'b0, RES_AR);
         6'o42:
            uword = microWord(6'o42, DISP_SCADSIGN, FUN_A_MINUS_1, ASEL_SC, BSEL_FE, 10'o0,
                              1'b1, 1'b0, DP_AR, SH_RIGHT, 1'b0, RES_AR);
         6'o25, 6'o43:
            uword = microWord(IDLE_ADDR, DISP_NONE, FUN_A, ASEL_SC, BSEL_FE, 10'o0,
                              1'b0, 1'b0, DP_AR, SH_HOLD, 1'b1, RES_AR);
         //////////////////////////////
         // FSC
         //////////////////////////////
         6'o30:
            uword = microWord(6'o31, DISP_NONE, FUN_A_PLUS_B, ASEL_SNUM, BSEL_SHIFT, 10'o0,
                              1'b1, 1'b0, DP_BR, SH_HOLD, 1'b0, RES_AR);
         // New exponent is count plus old exponent
         6'o31:
            uword = microWord(6'o32, DISP_NONE, FUN_A_PLUS_B, ASEL_SC, BSEL_EXP, 10'o0,
                              1'b0, 1'b1, DP_AR, SH_HOLD, 1'b0, RES_AR);
         6'o32:
            uword = microWord(IDLE_ADDR, DISP_NONE, FUN_A, ASEL_SC, BSEL_FE, 10'o0,
                              1'b0, 1'b0, DP_AR, SH_HOLD, 1'b1, RES_AR_WITH_FE);
         // Idle word and unused locations do nothing
         default:
            uword = microWord(IDLE_ADDR, DISP_NONE, FUN_A_PLUS_A, ASEL_SC, BSEL_FE, 10'o0,
                              1'b0, 1'b0, DP_AR, SH_HOLD, 1'b0, RES_AR);
      endcase
   end

endmodule

// ==== source/microSequencer.sv ====
// Microsequencer holding the micro-PC, branch dispatch and the req/ack handshake
`timescale 1ns/1ps

module microSequencer (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            req,
   input  logic [1:0]                      op,
   output logic                            ack,
   ucodeBus.sequencer                      bus,
   output logic [stepUnitPkg::UADDR_W-1:0] upc
);
   import stepUnitPkg::*;

   logic [J_W-1:0]     jump;
   logic [DISP_W-1:0]  disp;
   logic               done;
   logic               cond;
   logic               accept;
   logic [UADDR_W-1:0] entryAddr;
   logic [UADDR_W-1:0] nextAddr;

   // Sequencing fields of the current word
   assign jump = bus.uword[J_POS +: J_W];
   assign disp = bus.uword[DISP_POS +: DISP_W];
   assign done = bus.uword[DONE_POS];

   // Branch condition
   always_comb
   begin
      case (disp)
         DISP_NONE:     cond = 1'b0;
         DISP_SCADSIGN: cond = bus.scadSign;
         DISP_FRACMSB:  cond = bus.fracMsb;
         DISP_SCSIGN:   cond = bus.scSign;
      endcase
   end

   // Command to entry point
   always_comb
   begin
      case (op)
         OP_NORM: entryAddr = ENTRY_NORM;
         OP_LSH:  entryAddr = ENTRY_LSH;
         OP_FSC:  entryAddr = ENTRY_FSC;
         default: entryAddr = IDLE_ADDR;
      endcase
   end

   // New command only from idle with the last ack withdrawn
   assign accept    = (upc == IDLE_ADDR) && req && !ack;
   assign bus.start = accept;

   // KS-10 style branch with the condition in bit 0
   assign nextAddr = accept ? entryAddr : (jump | {{(UADDR_W-1){1'b0}}, cond});

   //////////////////////////////
   // Micro-PC and ack
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         upc <= IDLE_ADDR;
         ack <= 1'b0;
      end
      else
      begin
         upc <= nextAddr;
         // Ack holds until req drops
         if (done)
            ack <= 1'b1;
         else if (!req)
            ack <= 1'b0;
      end
   end

endmodule

// ==== source/scad.sv ====
// Step count adder with input muxes, eight-function ALU and the FE and SC registers
`timescale 1ns/1ps

module scad (
   input  logic   clk,
   input  logic   rst,
   ucodeBus.scad  bus
);
   import stepUnitPkg::*;

   logic [FUN_W-1:0]  fun;
   logic [ASEL_W-1:0] asel;
   logic [BSEL_W-1:0] bsel;
   logic [0:SCAD_W-1] snum;
   logic              loadSc;
   logic              loadFe;
   logic [0:SCAD_W-1] fe;
   logic [0:SCAD_W-1] sc;
   logic [0:SCAD_W-1] scadA;
   logic [0:SCAD_W-1] scadB;
   logic [0:WORD_W-1] dpRaw;
   dpWord_u           dp;

   // Microword fields
   assign fun    = bus.uword[FUN_POS +: FUN_W];
   assign asel   = bus.uword[ASEL_POS +: ASEL_W];
   assign bsel   = bus.uword[BSEL_POS +: BSEL_W];
   assign snum   = bus.uword[SNUM_POS +: SNUM_W];
   assign loadSc = bus.uword[LOADSC_POS];
   assign loadFe = bus.uword[LOADFE_POS];

   // Bit numbered copy for the byte fields, bit 0 is the MSB
   assign dp    = bus.dpBus;
   assign dpRaw = bus.dpBus;

   //////////////////////////////
   // SCADA mux
   //////////////////////////////

   // Byte selects interleave SC or SNUM edge bits with 7 bus bits
   always_comb
   begin
      case (asel)
         ASEL_SC:
            scadA = sc;
         ASEL_SNUM:
            scadA = snum;
         ASEL_PTR44:
            scadA = {sc[0], 6'o44, dpRaw[6], sc[8:9]};
         ASEL_BYTE1:
            scadA = {snum[0], dpRaw[0:6], snum[8:9]};
         ASEL_BYTE2:
            scadA = {sc[0], dpRaw[7:13], sc[8:9]};
         ASEL_BYTE3:
            scadA = {snum[0], dpRaw[14:20], snum[8:9]};
         ASEL_BYTE4:
            scadA = {sc[0], dpRaw[21:27], sc[8:9]};
         ASEL_BYTE5:
            scadA = {snum[0], dpRaw[28:34], snum[8:9]};
      endcase
   end

   //////////////////////////////
   // SCADB mux
   //////////////////////////////

   always_comb
   begin
      case (bsel)
         BSEL_FE:
            scadB = fe;
         // Exponent is stored one's complemented in negative words
         BSEL_EXP:
            if (dp.floatView.sign)
               scadB = {2'b00, ~dp.floatView.exponent};
            else
               scadB = {2'b00, dp.floatView.exponent};
         // Count sign from bit 18 extended over the top two bits
         BSEL_SHIFT:
            scadB = {dp.shiftView.countSign, dp.shiftView.countSign, dp.shiftView.count};
         BSEL_SIZE:
            scadB = {1'b0, dpRaw[6:11], 3'b000};
      endcase
   end

   // ALU map of the 181 functions the microcode names
   always_comb
   begin
      case (fun)
         FUN_A_PLUS_A:    bus.scadOut = scadA + scadA;
         FUN_A_OR_B:      bus.scadOut = scadA | scadB;
         FUN_A_MINUS_B_1: bus.scadOut = scadA - scadB - 1'b1;
         FUN_A_MINUS_B:   bus.scadOut = scadA - scadB;
         FUN_A_PLUS_B:    bus.scadOut = scadA + scadB;
         FUN_A_AND_B:     bus.scadOut = scadA & scadB;
         FUN_A_MINUS_1:   bus.scadOut = scadA - 1'b1;
         FUN_A:           bus.scadOut = scadA;
      endcase
   end

   // FE and SC both fed from the ALU
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fe <= '0;
         sc <= '0;
      end
      else
      begin
         if (loadFe)
            fe <= bus.scadOut;
         if (loadSc)
            sc <= bus.scadOut;
      end
   end

   // Sign bits for dispatch
   assign bus.scadSign = bus.scadOut[0];
   assign bus.scSign   = sc[0];
   assign bus.fe       = fe;

endmodule

// ==== source/dataPathRegs.sv ====
// AR and BR registers with the one-bit shifter, SCAD bus select and result assembly
`timescale 1ns/1ps

module dataPathRegs (
   input  logic                           clk,
   input  logic                           rst,
   ucodeBus.dataPath                      bus,
   input  logic [0:stepUnitPkg::WORD_W-1] opA,
   input  logic [0:stepUnitPkg::WORD_W-1] opB,
   output logic [0:stepUnitPkg::WORD_W-1] result
);
   import stepUnitPkg::*;

   logic [0:WORD_W-1]   ar;
   logic [0:WORD_W-1]   br;
   logic                argSign;
   logic [SHIFT_W-1:0]  shift;
   logic                dpSel;
   logic                done;
   logic [RESSEL_W-1:0] resSel;
   dpWord_u             arView;
   dpWord_u             assembled;

   // Microword controls
   assign shift  = bus.uword[SHIFT_POS +: SHIFT_W];
   assign dpSel  = bus.uword[DPSEL_POS];
   assign done   = bus.uword[DONE_POS];
   assign resSel = bus.uword[RESSEL_POS +: RESSEL_W];

   assign arView = ar;

   // SCAD sees AR or BR
   assign bus.dpBus   = (dpSel == DP_BR) ? br : ar;
   assign bus.fracMsb = arView.floatView.fraction[0];

   //////////////////////////////
   // AR, BR and operand sign
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ar      <= '0;
         br      <= '0;
         argSign <= 1'b0;
      end
      else if (bus.start)
      begin
         ar      <= opA;
         br      <= opB;
         argSign <= opA[0];
      end
      else
      begin
         // Zero fill at either end
         case (shift)
            SH_LEFT:  ar <= {ar[1:WORD_W-1], 1'b0};
            SH_RIGHT: ar <= {1'b0, ar[0:WORD_W-2]};
            default:  ar <= ar;
         endcase
      end
   end

   // Float result keeps the operand sign since normalize shifts run through bit 0
   always_comb
   begin
      assembled                    = arView;
      assembled.floatView.sign     = argSign;
      assembled.floatView.exponent = bus.fe[2:SCAD_W-1];
   end

   // Result captured by the done word
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         result <= '0;
      else if (done)
      begin
         case (resSel)
            RES_AR:         result <= ar;
            RES_AR_WITH_FE: result <= assembled;
            default:        result <= ar;
         endcase
      end
   end

endmodule

// ==== source/stepUnit.sv ====
// Microcoded step count unit running NORM, LSH and FSC under a req/ack handshake
`timescale 1ns/1ps

module stepUnit (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           req,
   input  logic [1:0]                     op,
   input  logic [0:stepUnitPkg::WORD_W-1] opA,
   input  logic [0:stepUnitPkg::WORD_W-1] opB,
   output logic                           ack,
   output logic [0:stepUnitPkg::WORD_W-1] result,
   output logic [0:stepUnitPkg::SCAD_W-1] exponent
);
   import stepUnitPkg::*;

   // Micro-PC into the ROM
   logic [UADDR_W-1:0] upc;

   // Shared microword and SCAD bundle
   ucodeBus uBus ();

   // ROM drives the bundle's microword
   controlStore i_controlStore (
      .addr  (upc),
      .uword (uBus.uword)
   );

   microSequencer i_microSequencer (
      .clk (clk),
      .rst (rst),
      .req (req),
      .op  (op),
      .ack (ack),
      .bus (uBus.sequencer),
      .upc (upc)
   );

   scad i_scad (
      .clk (clk),
      .rst (rst),
      .bus (uBus.scad)
   );

   dataPathRegs i_dataPathRegs (
      .clk    (clk),
      .rst    (rst),
      .bus    (uBus.dataPath),
      .opA    (opA),
      .opB    (opB),
      .result (result)
   );

   // FE straight out
   assign exponent = uBus.fe;

endmodule

// ==== bench/tbClock.sv ====
// Testbench clock source with a power-on reset held for a few cycles
`timescale 1ns/1ps

module tbClock (
   output logic clk,
   output logic rst
);
   localparam int PERIOD       = 20;
   localparam int RESET_CYCLES = 3;

   // Free running clock, low at time zero
   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset released on a falling edge
   initial
   begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

// ==== bench/stepUnit_chk.sv ====
// Handshake and result stability assertions for the step unit, bound into the top level
`timescale 1ns/1ps

module stepUnit_chk (
   input logic                           clk,
   input logic                           rst,
   input logic                           req,
   input logic                           ack,
   input logic [0:stepUnitPkg::WORD_W-1] result
);

   // Running tally of failed properties
   int failCount = 0;

   // Ack stays low while reset is applied
   ackLowInReset: assert property (@(posedge clk) rst |-> !ack)
      else
      begin
         failCount++;
         $error("ack high during reset");
      end

   // Ack only answers a pending req
   ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> $past(req))
      else
      begin
         failCount++;
         $error("ack rose without req");
      end

   // Ack withdrawn only once req has gone
   ackFallsAfterReq: assert property (@(posedge clk) disable iff (rst)
      $fell(ack) |-> !$past(req))
      else
      begin
         failCount++;
         $error("ack fell while req was still high");
      end

   // Result frozen for the whole ack phase
   resultStable: assert property (@(posedge clk) disable iff (rst)
      (ack && $past(ack)) |-> $stable(result))
      else
      begin
         failCount++;
         $error("result changed while ack was high");
      end

endmodule

bind stepUnit stepUnit_chk i_stepUnitChk (
   .clk    (clk),
   .rst    (rst),
   .req    (req),
   .ack    (ack),
   .result (result)
);

// ==== bench/stepUnitTb.sv ====
// Step unit testbench running random NORM, LSH and FSC commands against a reference model
`timescale 1ns/1ps

module stepUnitTb;
   import stepUnitPkg::*;

   localparam int CLK_PERIOD     = 20;
   localparam int CYCLES_PER_CMD = 300;
   localparam int NUM_NORM       = 40;
   localparam int NUM_LSH        = 40;
   localparam int NUM_FSC        = 30;
   localparam int NUM_MIXED      = 30;
   // Directed cases on top of the random ones
   localparam int NUM_CMDS       = NUM_NORM + NUM_LSH + NUM_FSC + NUM_MIXED + 15;

   logic              clk;
   logic              rst;
   logic              req;
   logic [1:0]        op;
   logic [0:WORD_W-1] opA;
   logic [0:WORD_W-1] opB;
   logic              ack;
   logic [0:WORD_W-1] result;
   logic [0:SCAD_W-1] exponent;

   int   checkCount   = 0;
   int   errorCount   = 0;
   int   cmdCount     = 0;
   int   ackRiseCount = 0;
   logic ackLast      = 1'b0;

   tbClock i_tbClock (
      .clk (clk),
      .rst (rst)
   );

   stepUnit i_stepUnit (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .op       (op),
      .opA      (opA),
      .opB      (opB),
      .ack      (ack),
      .result   (result),
      .exponent (exponent)
   );

   // Count ack rising edges, sampled away from the clock edge
   always @(negedge clk)
   begin
      if (ack === 1'b1 && ackLast !== 1'b1)
         ackRiseCount++;
      ackLast = ack;
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic logic [0:WORD_W-1] randWord();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return r[WORD_W-1:0];
   endfunction

   // Signed 9-bit count lives in bit 18 and bits 28 to 35
   function automatic logic [0:WORD_W-1] withCount(input logic [0:WORD_W-1] b, input int n);
      logic [8:0]        c;
      logic [0:WORD_W-1] w;
      c        = 9'(n);
      w        = b;
      w[18]    = c[8];
      w[28:35] = c[7:0];
      return w;
   endfunction

   function automatic int countOf(input logic [0:WORD_W-1] b);
      logic [8:0] c;
      c = {b[18], b[28:35]};
      return c[8] ? int'(c) - 512 : int'(c);
   endfunction

   // Normalize: shift the fraction up until its MSB is set, 27 tries at most
   task automatic normModel(input logic [0:WORD_W-1] a, output logic [0:WORD_W-1] res,
                            output logic [9:0] expo);
      logic [0:26] frac;
      int          k;
      frac = a[9:35];
      k    = 0;
      while (!frac[0] && k < 27)
      begin
         frac = frac << 1;
         k++;
      end
      expo = {2'b00, a[1:8]} - 10'(k);
      res  = {1'b0, expo[7:0], frac};
   endtask

   // Logical shift, left for positive counts, zero fill
   function automatic logic [0:WORD_W-1] lshModel(input logic [0:WORD_W-1] a,
                                                  input logic [0:WORD_W-1] b);
      int n;
      n = countOf(b);
      if (n < 0)
         return a >> (-n);
      else
         return a << n;
   endfunction

   // Exponent plus signed count, fraction untouched
   task automatic fscModel(input logic [0:WORD_W-1] a, input logic [0:WORD_W-1] b,
                           output logic [0:WORD_W-1] res, output logic [9:0] expo);
      expo = {2'b00, a[1:8]} + 10'(countOf(b));
      res  = {1'b0, expo[7:0], a[9:35]};
   endtask

   //////////////////////////////
   // Checks and stimulus
   //////////////////////////////

   task automatic checkValue(input string what, input logic [35:0] got, input logic [35:0] exp);
      checkCount++;
      if (got !== exp)
      begin
         errorCount++;
         $display("ERR %0d ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // Four-phase req/ack, called and left on a falling edge
   task automatic issueCommand(input logic [1:0] code, input logic [0:WORD_W-1] a,
                               input logic [0:WORD_W-1] b, output logic [0:WORD_W-1] res,
                               output logic [0:SCAD_W-1] expo);
      int waited;
      int hold;
      hold = int'($urandom % 4);
      cmdCount++;
      op  = code;
      opA = a;
      opB = b;
      req = 1'b1;
      waited = 0;
      while (ack !== 1'b1 && waited < CYCLES_PER_CMD)
      begin
         @(negedge clk);
         waited++;
      end
      if (ack !== 1'b1)
      begin
         errorCount++;
         $display("No ack within %0d cycles for command %0d (op %0d)", waited, cmdCount, code);
      end
      res  = result;
      expo = exponent;
      // Outputs frozen while req is kept up
      repeat (hold)
      begin
         @(negedge clk);
         checkValue("ack held under req", ack, 36'd1);
         checkValue("result held under ack", result, res);
      end
      req    = 1'b0;
      waited = 0;
      while (ack !== 1'b0 && waited < 4)
      begin
         @(negedge clk);
         waited++;
      end
      if (ack !== 1'b0)
      begin
         errorCount++;
         $display("Ack still high %0d cycles after req was withdrawn", waited);
      end
      repeat ($urandom % 4) @(negedge clk);
   endtask

   task automatic runCommand(input logic [1:0] code, input logic [0:WORD_W-1] a,
                             input logic [0:WORD_W-1] b);
      logic [0:WORD_W-1] expRes;
      logic [9:0]        expExp;
      logic [0:WORD_W-1] gotRes;
      logic [0:SCAD_W-1] gotExp;
      expExp = '0;
      case (code)
         OP_NORM: normModel(a, expRes, expExp);
         OP_FSC:  fscModel(a, b, expRes, expExp);
         default: expRes = lshModel(a, b);
      endcase
      issueCommand(code, a, b, gotRes, gotExp);
      checkValue($sformatf("op %0d a=%h b=%h result", code, a, b), gotRes, expRes);
      // LSH leaves FE alone
      if (code != OP_LSH)
         checkValue($sformatf("op %0d a=%h b=%h exponent", code, a, b), gotExp, expExp);
   endtask

   // Positive operands, fractions with random leading zeros
   task automatic makeOperands(input logic [1:0] code, output logic [0:WORD_W-1] a,
                               output logic [0:WORD_W-1] b);
      a    = randWord();
      b    = randWord();
      a[0] = 1'b0;
      if (code == OP_NORM)
         a[9:35] = a[9:35] >> ($urandom % 28);
      else if ($urandom % 2)
         b = withCount(b, int'($urandom % 81) - 40);
      else
         b = withCount(b, int'($urandom % 512) - 256);
   endtask

   task automatic reportTest(input string name, input int cmds, input int errBefore);
      if (errorCount == errBefore)
         $display("test %-9s %0d commands, ok", name, cmds);
      else
         $display("test %-9s %0d commands, %0d errors", name, cmds, errorCount - errBefore);
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial
   begin : mainFlow
      int                seedDummy;
      int                errBefore;
      int                firstCmd;
      logic [1:0]        code;
      logic [0:WORD_W-1] a;
      logic [0:WORD_W-1] b;
      int                edges[9];
      req       = 1'b0;
      op        = OP_NORM;
      opA       = '0;
      opB       = '0;
      seedDummy = $urandom(7054);
      edges     = '{0, 1, 35, 36, -1, -35, -36, 255, -256};

      // Reset: ack low, FE clear
      errBefore = errorCount;
      @(posedge clk);
      @(negedge clk);
      checkValue("ack during reset", ack, 36'd0);
      while (rst === 1'b1)
         @(negedge clk);
      @(negedge clk);
      checkValue("ack after reset", ack, 36'd0);
      checkValue("exponent after reset", exponent, 36'd0);
      reportTest("reset", 0, errBefore);

      // NORM, zero fraction and edge cases first
      errBefore = errorCount;
      firstCmd  = cmdCount;
      runCommand(OP_NORM, {1'b0, 8'o200, 27'd0}, '0);
      runCommand(OP_NORM, {1'b0, 8'd5, 27'd1}, '0);
      runCommand(OP_NORM, {1'b0, 8'd100, 1'b1, 26'd7}, '0);
      for (int i = 0; i < NUM_NORM; i++)
      begin
         makeOperands(OP_NORM, a, b);
         runCommand(OP_NORM, a, b);
      end
      reportTest("norm", cmdCount - firstCmd, errBefore);

      // LSH, boundary counts then random
      errBefore = errorCount;
      firstCmd  = cmdCount;
      foreach (edges[i])
         runCommand(OP_LSH, randWord(), withCount(randWord(), edges[i]));
      for (int i = 0; i < NUM_LSH; i++)
      begin
         makeOperands(OP_LSH, a, b);
         runCommand(OP_LSH, a, b);
      end
      reportTest("lsh", cmdCount - firstCmd, errBefore);

      // FSC with extreme counts too
      errBefore = errorCount;
      firstCmd  = cmdCount;
      runCommand(OP_FSC, {1'b0, 8'o200, 27'o1234567}, withCount('0, 0));
      runCommand(OP_FSC, {1'b0, 8'd3, 27'd9}, withCount('0, -256));
      runCommand(OP_FSC, {1'b0, 8'd250, 27'd9}, withCount('0, 255));
      for (int i = 0; i < NUM_FSC; i++)
      begin
         makeOperands(OP_FSC, a, b);
         runCommand(OP_FSC, a, b);
      end
      reportTest("fsc", cmdCount - firstCmd, errBefore);

      // Back to back mix, then one ack per req
      errBefore = errorCount;
      firstCmd  = cmdCount;
      for (int i = 0; i < NUM_MIXED; i++)
      begin
         code = 2'($urandom % 3);
         makeOperands(code, a, b);
         runCommand(code, a, b);
      end
      @(negedge clk);
      checkValue("ack rises per command", 36'(ackRiseCount), 36'(cmdCount));
      reportTest("handshake", cmdCount - firstCmd, errBefore);

      // Failed handshake properties count as errors too
      errorCount += i_stepUnit.i_stepUnitChk.failCount;

      $display("summary: %0d commands, %0d checks, %0d errors",
               cmdCount, checkCount, errorCount);
      if (errorCount == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   // Budget of cycles per command over the whole run
   initial
   begin : watchdog
      #(CLK_PERIOD * CYCLES_PER_CMD * (NUM_CMDS + 10));
      $display("Watchdog expired: the run took longer than the command budget allows");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== stepUnit.f ====
source/stepUnitPkg.sv
source/ucodeBus.sv
source/controlStore.sv
source/microSequencer.sv
source/scad.sv
source/dataPathRegs.sv
source/stepUnit.sv
bench/tbClock.sv
bench/stepUnit_chk.sv
bench/stepUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := stepUnitTb
FILELIST  := stepUnit.f
FLAGS     := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
